/* sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

    // opcode bits map straight onto {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LMR       = 4'd0,
        CMD_REFRESH   = 4'd1,
        CMD_PRECHARGE = 4'd2,
        CMD_ACTIVE    = 4'd3,
        CMD_WRITE     = 4'd4,
        CMD_NOP       = 4'd7
    } sdram_cmd_e;

    localparam int BANK_W = 2;
    localparam int ROW_W  = 12;  // also the width of the addr pins
    localparam int COL_W  = 8;
    localparam int DATA_W = 16;
    localparam int ADDR_W = BANK_W + ROW_W + COL_W;

    // mode register contents
    localparam logic [ROW_W-1:0] MODE_WORD = {
        2'b00,   // reserved
        1'b0,    // write burst follows programmed length
        2'b00,   // standard operation
        3'b011,  // cas latency 3
        1'b0,    // sequential
        3'b111   // full page
    };

endpackage

/* sdram_seq_pkg.sv */
package sdram_seq_pkg;

    typedef enum logic [1:0] {
        INIT,
        IDLE,
        REFRESH,
        WRITE
    } seq_state_e;

    // what decode hands to the sequencer
    typedef enum logic [1:0] {
        OP_NONE,
        OP_REFRESH,
        OP_WRITE
    } op_e;

    // auto refresh commands in the power-up sequence
    localparam int INIT_REFRESHES = 8;

endpackage

/* sdram_req_decode.sv */
`timescale 1ns/10ps

module sdram_req_decode
    import sdram_cmd_pkg::*, sdram_seq_pkg::*;
#(
    parameter logic [15:0] REFRESH_PERIOD = 16'd60
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              seq_idle,
    input  logic              init_done,
    output logic              op_go,
    output op_e               op,
    output logic [ROW_W-1:0]  req_row,
    output logic [COL_W-1:0]  req_col,
    output logic [BANK_W-1:0] req_bank,
    output logic [DATA_W-1:0] req_data
);

    logic        write_pending;
    logic        ref_pending;
    logic [15:0] ref_cnt;
    logic        ref_end;

    always_ff @(posedge clk) begin
        if (wr_req) begin
            req_bank <= waddr[ADDR_W-1 -: BANK_W];
            req_row  <= waddr[COL_W +: ROW_W];
            req_col  <= waddr[COL_W-1:0];
            req_data <= wdata;
        end
    end

    // refresh timer runs free once init is over
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_cnt <= '0;
        end else if (init_done) begin
            if (ref_end)
                ref_cnt <= '0;
            else
                ref_cnt <= ref_cnt + 16'd1;
        end
    end

    assign ref_end = init_done && ref_cnt == REFRESH_PERIOD - 16'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_pending <= 1'b0;
        end else if (ref_end) begin
            ref_pending <= 1'b1;
        end else if (op_go && op == OP_REFRESH) begin
            ref_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_pending <= 1'b0;
        end else if (wr_req) begin
            write_pending <= 1'b1;
        end else if (op_go && op == OP_WRITE) begin
            write_pending <= 1'b0;
        end
    end

    // refresh beats a waiting write
    always_comb begin
        op = OP_NONE;
        if (ref_pending)
            op = OP_REFRESH;
        else if (write_pending)
            op = OP_WRITE;
    end

    assign op_go = seq_idle && op != OP_NONE;

    a_no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> !write_pending)
        else $error("wr_req strobed again before wr_ack");

endmodule

/* sdram_sequencer.sv */
`timescale 1ns/10ps

module sdram_sequencer
    import sdram_cmd_pkg::*, sdram_seq_pkg::*;
#(
    parameter logic [15:0] T_STABLE  = 16'd200,
    parameter logic [15:0] T_RP      = 16'd3,
    parameter logic [15:0] T_RC      = 16'd7,
    parameter logic [15:0] T_MRD     = 16'd3,
    parameter logic [15:0] T_RCD     = 16'd3,
    parameter logic [15:0] BURST_LEN = 16'd256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_go,
    input  op_e               op,
    input  logic [ROW_W-1:0]  req_row,
    input  logic [COL_W-1:0]  req_col,
    input  logic [BANK_W-1:0] req_bank,
    input  logic [DATA_W-1:0] req_data,
    output logic              seq_idle,
    output logic              init_done,
    output logic              in_init,
    output logic              cmd_go,
    output sdram_cmd_e        cmd,
    output logic [ROW_W-1:0]  cmd_addr,
    output logic [BANK_W-1:0] cmd_bank,
    output logic              burst_start,
    output logic [DATA_W-1:0] burst_data
);

    // init runs stable, precharge, one phase per refresh, then lmr
    localparam logic [3:0] INIT_PHASES = 4'(INIT_REFRESHES + 3);
    localparam logic [3:0] LMR_PHASE   = INIT_PHASES - 4'd1;
    localparam logic [ROW_W-1:0] A10   = ROW_W'(1 << 10);

    seq_state_e state_c;
    seq_state_e state_n;

    logic [15:0] cnt_sub;
    logic [3:0]  cnt_phase;
    logic [15:0] sub_lim;
    logic [3:0]  phase_lim;
    logic        add_sub;
    logic        end_sub;
    logic        end_phase;
    logic        phase_start;

    logic [ROW_W-1:0]  lat_row;
    logic [COL_W-1:0]  lat_col;
    logic [BANK_W-1:0] lat_bank;
    logic [DATA_W-1:0] lat_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_c <= INIT;
        else
            state_c <= state_n;
    end

    always_comb begin
        state_n = state_c;
        case (state_c)
            INIT: begin
                if (end_phase)
                    state_n = IDLE;
            end
            IDLE: begin
                if (op_go && op == OP_REFRESH)
                    state_n = REFRESH;
                else if (op_go && op == OP_WRITE)
                    state_n = WRITE;
            end
            REFRESH, WRITE: begin
                if (end_phase)
                    state_n = IDLE;
            end
            default: state_n = IDLE;
        endcase
    end

    // phase lengths per state
    always_comb begin
        phase_lim = 4'd1;
        sub_lim   = 16'd1;
        case (state_c)
            INIT: begin
                phase_lim = INIT_PHASES;
                if (cnt_phase == 4'd0)
                    sub_lim = T_STABLE;
                else if (cnt_phase == 4'd1)
                    sub_lim = T_RP;
                else if (cnt_phase == LMR_PHASE)
                    sub_lim = T_MRD;
                else
                    sub_lim = T_RC;
            end
            REFRESH: sub_lim = T_RC;
            WRITE: begin
                phase_lim = 4'd3;
                if (cnt_phase == 4'd0)
                    sub_lim = T_RCD;
                else if (cnt_phase == 4'd1)
                    sub_lim = BURST_LEN;
                else
                    sub_lim = T_RP;
            end
            default: ;
        endcase
    end

    assign add_sub   = state_c != IDLE;
    assign end_sub   = add_sub && cnt_sub == sub_lim - 16'd1;
    assign end_phase = end_sub && cnt_phase == phase_lim - 4'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_sub <= '0;
        end else if (add_sub) begin
            if (end_sub)
                cnt_sub <= '0;
            else
                cnt_sub <= cnt_sub + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_phase <= '0;
        end else if (end_sub) begin
            if (end_phase)
                cnt_phase <= '0;
            else
                cnt_phase <= cnt_phase + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            init_done <= 1'b0;
        else if (state_c == INIT && end_phase)
            init_done <= 1'b1;
    end

    // hold the request so a new strobe after wr_ack can't disturb precharge
    always_ff @(posedge clk) begin
        if (op_go && op == OP_WRITE) begin
            lat_row  <= req_row;
            lat_col  <= req_col;
            lat_bank <= req_bank;
            lat_data <= req_data;
        end
    end

    assign seq_idle    = state_c == IDLE;
    assign in_init     = state_c == INIT;
    assign phase_start = add_sub && cnt_sub == 16'd0;
    assign cmd_go      = phase_start && !(state_c == INIT && cnt_phase == 4'd0);
    assign burst_start = phase_start && state_c == WRITE && cnt_phase == 4'd1;
    assign burst_data  = lat_data;

    always_comb begin
        cmd      = CMD_NOP;
        cmd_addr = '0;
        cmd_bank = '0;
        case (state_c)
            INIT: begin
                if (cnt_phase == 4'd1) begin
                    cmd      = CMD_PRECHARGE;
                    cmd_addr = A10;          // all banks
                end else if (cnt_phase == LMR_PHASE) begin
                    cmd      = CMD_LMR;
                    cmd_addr = MODE_WORD;
                end else if (cnt_phase != 4'd0) begin
                    cmd      = CMD_REFRESH;
                end
            end
            REFRESH: cmd = CMD_REFRESH;
            WRITE: begin
                cmd_bank = lat_bank;
                if (cnt_phase == 4'd0) begin
                    cmd      = CMD_ACTIVE;
                    cmd_addr = lat_row;
                end else if (cnt_phase == 4'd1) begin
                    cmd      = CMD_WRITE;
                    cmd_addr = {{(ROW_W-COL_W){1'b0}}, lat_col};  // no auto precharge
                end else begin
                    cmd      = CMD_PRECHARGE;  // a10 low so only this bank closes
                end
            end
            default: ;
        endcase
    end

    a_op_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        op_go |-> state_c == IDLE)
        else $error("operation launched while sequencer busy");

endmodule

/* sdram_pin_driver.sv */
`timescale 1ns/10ps

module sdram_pin_driver
    import sdram_cmd_pkg::*;
#(
    parameter logic [15:0] BURST_LEN = 16'd256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_go,
    input  sdram_cmd_e        cmd,
    input  logic [ROW_W-1:0]  cmd_addr,
    input  logic [BANK_W-1:0] cmd_bank,
    input  logic              burst_start,
    input  logic [DATA_W-1:0] burst_data,
    input  logic              in_init,
    output logic              cs_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic [ROW_W-1:0]  addr,
    output logic [BANK_W-1:0] bank,
    output logic              dqm,
    output logic [DATA_W-1:0] dq,
    output logic              dq_oe,
    output logic              wr_ack
);

    sdram_cmd_e  cmd_r;
    logic [15:0] beat_left;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cmd_r <= CMD_NOP;
        else if (cmd_go)
            cmd_r <= cmd;
        else
            cmd_r <= CMD_NOP;
    end

    assign {cs_n, ras_n, cas_n, we_n} = cmd_r;

    // addr and bank stay put between commands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
            bank <= '0;
        end else if (cmd_go) begin
            addr <= cmd_addr;
            bank <= cmd_bank;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dqm    <= 1'b1;
            wr_ack <= 1'b0;
        end else begin
            dqm    <= in_init;  // masked during power-up
            wr_ack <= burst_start;
        end
    end

    // dq_oe covers the whole burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dq_oe     <= 1'b0;
            beat_left <= '0;
        end else if (burst_start) begin
            dq_oe     <= 1'b1;
            beat_left <= BURST_LEN - 16'd1;
        end else if (dq_oe) begin
            if (beat_left == 16'd0)
                dq_oe <= 1'b0;
            else
                beat_left <= beat_left - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (burst_start)
            dq <= burst_data;
    end

    a_burst_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        burst_start |-> cmd_go && cmd == CMD_WRITE)
        else $error("burst started without a WRITE command");

endmodule

/* sdram_write_ctrl.sv */
`timescale 1ns/10ps

module sdram_write_ctrl
    import sdram_cmd_pkg::*, sdram_seq_pkg::*;
#(
    parameter logic [15:0] T_STABLE       = 16'd200,
    parameter logic [15:0] T_RP           = 16'd3,
    parameter logic [15:0] T_RC           = 16'd7,
    parameter logic [15:0] T_MRD          = 16'd3,
    parameter logic [15:0] T_RCD          = 16'd3,
    parameter logic [15:0] BURST_LEN      = 16'd256,
    parameter logic [15:0] REFRESH_PERIOD = 16'd780
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    output logic              wr_ack,
    output logic              cke,
    output logic              cs_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic              dqm,
    output logic [ROW_W-1:0]  addr,
    output logic [BANK_W-1:0] bank,
    output logic [DATA_W-1:0] dq,
    output logic              dq_oe
);

    logic              op_go;
    op_e               op;
    logic [ROW_W-1:0]  req_row;
    logic [COL_W-1:0]  req_col;
    logic [BANK_W-1:0] req_bank;
    logic [DATA_W-1:0] req_data;
    logic              seq_idle;
    logic              init_done;
    logic              in_init;
    logic              cmd_go;
    sdram_cmd_e        cmd;
    logic [ROW_W-1:0]  cmd_addr;
    logic [BANK_W-1:0] cmd_bank;
    logic              burst_start;
    logic [DATA_W-1:0] burst_data;

    assign cke = 1'b1;  // no power-down support

    sdram_req_decode #(
        .REFRESH_PERIOD(REFRESH_PERIOD)
    ) u_decode (
        .clk(clk), .rst_n(rst_n), .wr_req(wr_req), .waddr(waddr), .wdata(wdata),
        .seq_idle(seq_idle), .init_done(init_done), .op_go(op_go), .op(op),
        .req_row(req_row), .req_col(req_col), .req_bank(req_bank), .req_data(req_data)
    );

    sdram_sequencer #(
        .T_STABLE(T_STABLE), .T_RP(T_RP), .T_RC(T_RC), .T_MRD(T_MRD),
        .T_RCD(T_RCD), .BURST_LEN(BURST_LEN)
    ) u_sequencer (
        .clk(clk), .rst_n(rst_n), .op_go(op_go), .op(op),
        .req_row(req_row), .req_col(req_col), .req_bank(req_bank), .req_data(req_data),
        .seq_idle(seq_idle), .init_done(init_done), .in_init(in_init),
        .cmd_go(cmd_go), .cmd(cmd), .cmd_addr(cmd_addr), .cmd_bank(cmd_bank),
        .burst_start(burst_start), .burst_data(burst_data)
    );

    sdram_pin_driver #(
        .BURST_LEN(BURST_LEN)
    ) u_pins (
        .clk(clk), .rst_n(rst_n), .cmd_go(cmd_go), .cmd(cmd),
        .cmd_addr(cmd_addr), .cmd_bank(cmd_bank), .burst_start(burst_start),
        .burst_data(burst_data), .in_init(in_init),
        .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
        .addr(addr), .bank(bank), .dqm(dqm), .dq(dq), .dq_oe(dq_oe), .wr_ack(wr_ack)
    );

endmodule

/* tb_sdram_write.sv */
`timescale 1ns/10ps

module tb_sdram_write
    import sdram_cmd_pkg::*, sdram_seq_pkg::*;
;

    localparam int T_STABLE       = 20;
    localparam int T_RP           = 3;
    localparam int T_RC           = 7;
    localparam int T_MRD          = 3;
    localparam int T_RCD          = 3;
    localparam int BURST_LEN      = 16;
    localparam int REFRESH_PERIOD = 150;
    // a refresh can be held back by at most one write in flight
    localparam int REF_GAP_MAX    = REFRESH_PERIOD + T_RCD + BURST_LEN + T_RP;
    localparam int INIT_CMDS      = INIT_REFRESHES + 2;
    localparam int INIT_TIMEOUT   = T_STABLE + T_RP + (INIT_REFRESHES + 1) * T_RC + T_MRD + 20;
    localparam int ACK_TIMEOUT    = 100;
    localparam int END_TIMEOUT    = 3 * REFRESH_PERIOD;
    localparam logic [ROW_W-1:0] A10      = ROW_W'(1 << 10);
    localparam logic [ROW_W-1:0] ALL_BITS = '1;

    logic              clk;
    logic              rst_n;
    logic              wr_req;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              wr_ack;
    logic              cke;
    logic              cs_n;
    logic              ras_n;
    logic              cas_n;
    logic              we_n;
    logic              dqm;
    logic [ROW_W-1:0]  addr;
    logic [BANK_W-1:0] bank;
    logic [DATA_W-1:0] dq;
    logic              dq_oe;

    // monitor state
    int                cyc;
    int                init_step = 0;
    int                exp_cycle = T_STABLE + 1;
    int                act_cycle = 0;
    int                wr_cycle = 0;
    int                burst_left = 0;
    int                last_cycle = 0;
    int                last_ref = 0;
    int                auto_refs = 0;
    bit                in_row = 1'b0;
    bit                wrote = 1'b0;
    sdram_cmd_e        c;
    sdram_cmd_e        last_cmd = CMD_NOP;
    logic [BANK_W-1:0] cur_bank;
    logic [ROW_W-1:0]  cur_row;
    logic [COL_W-1:0]  cur_col;
    logic [DATA_W-1:0] cur_data;

    // writes sent but not yet seen as ACTIVE
    logic [BANK_W-1:0] q_bank[$];
    logic [ROW_W-1:0]  q_row[$];
    logic [COL_W-1:0]  q_col[$];
    logic [DATA_W-1:0] q_data[$];

    sdram_write_ctrl #(
        .T_STABLE(16'(T_STABLE)), .T_RP(16'(T_RP)), .T_RC(16'(T_RC)), .T_MRD(16'(T_MRD)),
        .T_RCD(16'(T_RCD)), .BURST_LEN(16'(BURST_LEN)),
        .REFRESH_PERIOD(16'(REFRESH_PERIOD))
    ) dut (
        .clk(clk), .rst_n(rst_n), .wr_req(wr_req), .waddr(waddr), .wdata(wdata),
        .wr_ack(wr_ack), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n),
        .we_n(we_n), .dqm(dqm), .addr(addr), .bank(bank), .dq(dq), .dq_oe(dq_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cyc <= 0;
        else
            cyc <= cyc + 1;  // rising edges since reset release
    end

    task automatic stop_run(input string text);
        $display("%s", text);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("FAILED at time %0d ns: %s", $time, msg));
    endtask

    task automatic check_cmd(input sdram_cmd_e want, input sdram_cmd_e got, input string what);
        if (got !== want)
            report_error($sformatf("%s: expected %s, got %s (%0h)", what, want.name(),
                got.name(), got));
    endtask

    task automatic check_addr(input logic [ROW_W-1:0] want_addr,
                              input logic [BANK_W-1:0] want_bank,
                              input logic [ROW_W-1:0] mask,
                              input logic [ROW_W-1:0] got_addr,
                              input logic [BANK_W-1:0] got_bank,
                              input string what);
        if ((got_addr & mask) !== (want_addr & mask) || got_bank !== want_bank)
            report_error($sformatf("%s: expected addr %h bank %0d, got addr %h bank %0d",
                what, want_addr & mask, want_bank, got_addr & mask, got_bank));
    endtask

    task automatic check_data(input logic [DATA_W-1:0] want, input logic [DATA_W-1:0] got,
                              input string what);
        if (got !== want)
            report_error($sformatf("%s: expected %h, got %h", what, want, got));
    endtask

    task automatic check_spacing();
        if (last_cmd == CMD_REFRESH && cyc - last_cycle < T_RC)
            report_error($sformatf("%s only %0d cycles after REFRESH", c.name(),
                cyc - last_cycle));
        if (last_cmd == CMD_PRECHARGE && cyc - last_cycle < T_RP)
            report_error($sformatf("%s only %0d cycles after PRECHARGE", c.name(),
                cyc - last_cycle));
        last_cmd   = c;
        last_cycle = cyc;
    endtask

    task automatic check_init_cmd();
        if (cyc != exp_cycle)
            report_error($sformatf("init command %0d at cycle %0d, expected cycle %0d",
                init_step, cyc, exp_cycle));
        if (init_step == 0) begin
            check_cmd(CMD_PRECHARGE, c, "init precharge");
            if (addr[10] !== 1'b1)
                report_error("init PRECHARGE without addr[10] high");
            exp_cycle = cyc + T_RP;
        end else if (init_step <= INIT_REFRESHES) begin
            check_cmd(CMD_REFRESH, c, "init refresh");
            exp_cycle = cyc + T_RC;
        end else begin
            check_cmd(CMD_LMR, c, "mode register load");
            check_addr(MODE_WORD, '0, ALL_BITS, addr, bank, "mode word");
        end
        init_step++;
    endtask

    task automatic check_run_cmd();
        case (c)
            CMD_ACTIVE: begin
                if (in_row)
                    report_error("ACTIVE while a row is still open");
                if (q_bank.size() == 0)
                    report_error("ACTIVE with no write request waiting");
                cur_bank = q_bank.pop_front();
                cur_row  = q_row.pop_front();
                cur_col  = q_col.pop_front();
                cur_data = q_data.pop_front();
                check_addr(cur_row, cur_bank, ALL_BITS, addr, bank, "ACTIVE row");
                in_row    = 1'b1;
                wrote     = 1'b0;
                act_cycle = cyc;
            end
            CMD_WRITE: begin
                if (!in_row || wrote)
                    report_error("WRITE outside an ACTIVE window");
                if (cyc != act_cycle + T_RCD)
                    report_error($sformatf("WRITE %0d cycles after ACTIVE", cyc - act_cycle));
                check_addr(ROW_W'(cur_col), cur_bank, ALL_BITS, addr, bank, "WRITE column");
                if (wr_ack !== 1'b1)
                    report_error("no wr_ack with WRITE");
                if (dqm !== 1'b0)
                    report_error("dqm high with WRITE");
                wrote      = 1'b1;
                wr_cycle   = cyc;
                burst_left = BURST_LEN;
            end
            CMD_PRECHARGE: begin
                if (!wrote)
                    report_error("PRECHARGE without a WRITE before it");
                if (cyc != wr_cycle + BURST_LEN)
                    report_error($sformatf("PRECHARGE %0d cycles after WRITE", cyc - wr_cycle));
                check_addr('0, cur_bank, A10, addr, bank, "bank precharge");
                in_row = 1'b0;
                wrote  = 1'b0;
            end
            CMD_REFRESH: begin
                if (in_row)
                    report_error("REFRESH inside an ACTIVE to PRECHARGE window");
                if (auto_refs > 0 && cyc - last_ref > REF_GAP_MAX)
                    report_error($sformatf("refreshes %0d cycles apart", cyc - last_ref));
                last_ref = cyc;
                auto_refs++;
            end
            default: report_error($sformatf("unexpected command %s", c.name()));
        endcase
    endtask

    task automatic check_burst_beat();
        if (burst_left > 0) begin
            if (dq_oe !== 1'b1)
                report_error("dq_oe low during the burst");
            check_data(cur_data, dq, "burst data");
            burst_left--;
        end else if (dq_oe !== 1'b0) begin
            report_error("dq_oe high outside a burst");
        end
    endtask

    // pins are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            c = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
            if (cke !== 1'b1)
                report_error("cke dropped");
            if (c != CMD_NOP) begin
                check_spacing();
                if (init_step < INIT_CMDS)
                    check_init_cmd();
                else
                    check_run_cmd();
            end
            if (init_step < INIT_CMDS && dqm !== 1'b1)
                report_error("dqm low during power-up");
            if (wr_ack === 1'b1 && c != CMD_WRITE)
                report_error("wr_ack without a WRITE on the pins");
            check_burst_beat();
        end
    end

    task automatic check_reset_pins();
        check_cmd(CMD_NOP, sdram_cmd_e'({cs_n, ras_n, cas_n, we_n}), "pins in reset");
        if (wr_ack !== 1'b0 || dq_oe !== 1'b0 || cke !== 1'b1 || dqm !== 1'b1)
            report_error("wr_ack, dq_oe, cke or dqm wrong in reset");
    endtask

    task automatic send_write(input logic [BANK_W-1:0] b, input logic [ROW_W-1:0] r,
                              input logic [COL_W-1:0] col, input logic [DATA_W-1:0] d);
        @(posedge clk);
        #2;
        wr_req = 1'b1;
        waddr  = {b, r, col};
        wdata  = d;
        q_bank.push_back(b);
        q_row.push_back(r);
        q_col.push_back(col);
        q_data.push_back(d);
        @(posedge clk);
        #2;
        wr_req = 1'b0;
    endtask

    task automatic wait_ack(input int idx);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = wr_ack === 1'b1;
            n++;
            if (!seen && n >= ACK_TIMEOUT)
                stop_run($sformatf("Timeout: wr_ack never came for pattern %0d", idx));
        end
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (init_step < INIT_CMDS) begin
            @(posedge clk);
            n++;
            if (n >= INIT_TIMEOUT)
                stop_run("Timeout: the power-up sequence never finished");
        end
    endtask

    task automatic wait_quiet();
        int n;
        n = 0;
        while (auto_refs < 2 || in_row || burst_left != 0) begin
            @(posedge clk);
            n++;
            if (n >= END_TIMEOUT)
                stop_run("Timeout: no second auto refresh or last write never closed");
        end
    endtask

    initial begin
        int                fd;
        int                gap;
        int                npat;
        string             line;
        logic [BANK_W-1:0] p_bank;
        logic [ROW_W-1:0]  p_row;
        logic [COL_W-1:0]  p_col;
        logic [DATA_W-1:0] p_data;

        rst_n  = 1'b0;
        wr_req = 1'b0;
        waddr  = '0;
        wdata  = '0;
        npat   = 0;
        fd = $fopen("write_patterns.txt", "r");
        if (fd == 0)
            stop_run("Could not open write_patterns.txt");

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_reset_pins();
        @(posedge clk);
        #2 rst_n = 1'b1;
        wait_init();

        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;  // header or blank
            if ($sscanf(line, "%d %h %h %h %h", gap, p_bank, p_row, p_col, p_data) != 5)
                stop_run({"Bad line in write_patterns.txt: ", line});
            repeat (gap) @(posedge clk);
            send_write(p_bank, p_row, p_col, p_data);
            wait_ack(npat);
            npat++;
        end
        $fclose(fd);

        wait_quiet();
        if (npat == 0 || q_bank.size() != 0) begin
            stop_run("Writes were not all served, or no pattern was read");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* write_patterns.txt */
# columns: idle gap (decimal cycles), bank, row, column, data (all hex after the gap)
# one write per line, wr_req is strobed after the gap
0  0 000 00 1234
0  1 001 01 abcd
3  2 7ff ff 5a5a
0  3 fff 80 a5a5
12 0 123 45 0001
0  1 456 7f 8000
25 2 800 10 ffff
0  3 0aa 55 0000
5  0 555 aa c3c3
40 1 3c3 3c 3c3c
0  2 a5a 5a 1111
7  3 5a5 a5 2222
0  0 fff ff dead
60 1 000 00 beef
2  2 111 22 cafe
0  3 222 33 f00d
18 0 333 44 0f0f
0  1 444 66 f0f0

/* tb.f */
sdram_cmd_pkg.sv
sdram_seq_pkg.sv
sdram_req_decode.sv
sdram_sequencer.sv
sdram_pin_driver.sv
sdram_write_ctrl.sv
tb_sdram_write.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SDRAM write controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_sdram_write -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_sdram_write; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0
